/* Makefile */
# Verilator flow for the accelerator wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_hwpe_sm
RTL_TOP   ?= hwpe_sm_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/hwpe_sm_golden.txt */
# cmd addr data : W writes data, R reads and expects data, I waits for an interrupt
# T name opens a test, G n sets the largest random idle gap in cycles
T reset_acquire
R 002 00000000
R 001 00000000
R 001 FFFFFFFF
T add_job
W 004 00000000
W 005 89ABCDEF
W 006 87654321
W 000 00000001
I
R 007 11111110
R 002 00000000
T sub_xor_mul
R 001 00000001
W 004 00000001
W 005 00000010
W 006 00000025
W 000 00000001
I
R 00F FFFFFFEB
R 001 00000000
W 004 00000002
W 005 12345678
W 006 0F0F0F0F
W 000 00000001
I
R 007 1D3B5977
R 001 00000001
W 004 00000003
W 005 0000FFFF
W 006 0000FFFF
W 000 00000001
I
R 00F FFFE0001
T queueing
R 001 00000000
W 004 00000003
W 005 ABCD1234
W 006 98760100
G 0
W 000 00000001
R 001 00000001
# context 1 keeps its mul opcode from the previous test
W 005 00010101
W 006 00000011
W 000 00000001
R 002 00000005
R 001 FFFFFFFF
G 3
I
I
R 007 00123400
R 00F 00001111
R 002 00000000
T result_trigger
W 007 DEADBEEF
R 007 00123400
R 000 00000000
R 008 00000000

/* sim/tb_clkgen.sv */
// ************************************************
// Testbench clock source, 4 ns period
// ************************************************

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  localparam int HALF_PERIOD_NS = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

/* sim/tb_hwpe_sm.sv */
// ************************************************
// Accelerator wrapper testbench
// Replays bus operations from the golden file,
// checks read data and completion interrupts
// ************************************************

`timescale 1ns/1ps

module tb_hwpe_sm import hwpe_sm_pkg::*; ();

  localparam int          CYCLES_PER_LINE = 120;
  localparam int          IRQ_TIMEOUT     = 100;
  localparam logic [31:0] RANDOM_SEED     = 32'h94bb_2f56;
  localparam string       GOLDEN_FILE     = "sim/hwpe_sm_golden.txt";

  logic                      clk_gated;
  logic                      rst_n;
  logic                      data_req_i;
  logic [CFG_ADDR_WIDTH-1:0] data_add_i;
  logic                      data_type_i;
  logic [CFG_DATA_WIDTH-1:0] data_wdata_i;
  logic [CFG_DATA_WIDTH-1:0] data_r_rdata_o;
  logic                      data_r_valid_o;
  logic                      evt_interrupt_o;

  int          watchdog_cycles = 0;
  int          max_gap = 3;
  int          irq_count = 0;
  int          irq_taken = 0;
  logic        irq_prev = 1'b0;
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic        test_open = 1'b0;
  logic [8*32-1:0] test_name;

  tb_clkgen clkgen0 (.clk_o(clk_gated));

  hwpe_sm_top dut0 (
    .clk_gated       (clk_gated),
    .rst_n           (rst_n),
    .data_req_i      (data_req_i),
    .data_add_i      (data_add_i),
    .data_type_i     (data_type_i),
    .data_wdata_i    (data_wdata_i),
    .data_r_rdata_o  (data_r_rdata_o),
    .data_r_valid_o  (data_r_valid_o),
    .evt_interrupt_o (evt_interrupt_o)
  );

  // Count interrupt pulses so none is lost between waits
  always @(negedge clk_gated) begin
    if (rst_n && evt_interrupt_o && !irq_prev) begin
      irq_count = irq_count + 1;
    end
    irq_prev = evt_interrupt_o;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL t=%0t %s expected=%08h actual=%08h", $time, name, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = int'($urandom % 32'(max_gap + 1));
    repeat (gap) @(posedge clk_gated);
  endtask

  // Request held for two cycles, dropped on the acting edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_gated);
    data_req_i   <= 1'b1;
    data_add_i   <= addr[CFG_ADDR_WIDTH-1:0];
    data_type_i  <= 1'b1;
    data_wdata_i <= data;
    repeat (2) @(posedge clk_gated);
    data_req_i <= 1'b0;
    idle_gap();
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
    @(posedge clk_gated);
    data_req_i   <= 1'b1;
    data_add_i   <= addr[CFG_ADDR_WIDTH-1:0];
    data_type_i  <= 1'b0;
    data_wdata_i <= '0;
    repeat (2) @(posedge clk_gated);
    data_req_i <= 1'b0;
    // Response is due in the cycle right after the acting edge
    @(negedge clk_gated);
    if (data_r_valid_o) begin
      check_value($sformatf("data_r_rdata_o[%03h]", addr[CFG_ADDR_WIDTH-1:0]),
                  expected, data_r_rdata_o);
    end else begin
      $display("Read of address %03h got no response in the expected cycle",
               addr[CFG_ADDR_WIDTH-1:0]);
      test_errors++;
      total_errors++;
    end
    idle_gap();
  endtask

  task automatic wait_interrupt();
    int cycles;
    cycles = 0;
    while (irq_count == irq_taken && cycles < IRQ_TIMEOUT) begin
      @(posedge clk_gated);
      cycles++;
    end
    if (irq_count > irq_taken) begin
      irq_taken++;
    end else begin
      $display("Interrupt did not arrive within %0d cycles", IRQ_TIMEOUT);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic close_test();
    if (test_open) begin
      if (test_errors == 0) begin
        $display("Test %0s: ok", test_name);
        tests_passed++;
      end else begin
        $display("Test %0s: %0d errors", test_name, test_errors);
        tests_failed++;
      end
    end
    test_open   = 1'b0;
    test_errors = 0;
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_gated);
    $display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int              fd;
    int              code;
    int              line_count;
    logic            reading;
    logic [7:0]      cmd;
    logic [31:0]     addr;
    logic [31:0]     data;
    logic [8*160-1:0] line;

    rst_n        = 1'b0;
    data_req_i   = 1'b0;
    data_add_i   = '0;
    data_type_i  = 1'b0;
    data_wdata_i = '0;
    void'($urandom(RANDOM_SEED));

    // Run length follows from the size of the golden file
    line_count = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %s", GOLDEN_FILE);
      total_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0) begin
          line_count++;
        end
      end
      $fclose(fd);
    end
    watchdog_cycles = line_count * CYCLES_PER_LINE;

    repeat (2) @(posedge clk_gated);
    rst_n <= 1'b1;
    @(posedge clk_gated);

    fd      = $fopen(GOLDEN_FILE, "r");
    reading = (fd != 0);
    while (reading) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        reading = 1'b0;
      end else begin
        case (cmd)
          "#": code = $fgets(line, fd);
          "T": begin
            close_test();
            code      = $fscanf(fd, "%s", test_name);
            test_open = 1'b1;
          end
          "G": code = $fscanf(fd, "%d", max_gap);
          "W": begin
            code = $fscanf(fd, "%h %h", addr, data);
            bus_write(addr, data);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", addr, data);
            bus_read(addr, data);
          end
          "I": wait_interrupt();
          default: begin
            $display("Unknown command '%c' in the golden file", cmd);
            test_errors++;
            total_errors++;
            code = $fgets(line, fd);
          end
        endcase
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    close_test();

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/hwpe_sm_pkg.sv
verilog/hwpe_sm_slave.sv
verilog/hwpe_sm_regfile.sv
verilog/hwpe_sm_engine.sv
verilog/hwpe_sm_top.sv
sim/tb_clkgen.sv
sim/tb_hwpe_sm.sv

/* verilog/hwpe_sm_engine.sv */
// ************************************************
// Accelerator wrapper arithmetic engine
// Single-cycle add, sub, xor and a 16-step
// shift-add multiply, one job per handshake
// ************************************************

`timescale 1ns/1ps

module hwpe_sm_engine import hwpe_sm_pkg::*; (
  input  logic                      clk_gated,
  input  logic                      rst_n,

  input  logic                      job_req_i,
  output logic                      job_ack_o,

  input  engine_op_e                opcode_i,
  input  logic [CFG_DATA_WIDTH-1:0] operand_a_i,
  input  logic [CFG_DATA_WIDTH-1:0] operand_b_i,

  output logic                      result_we_o,
  output logic [CFG_DATA_WIDTH-1:0] result_data_o
);

  eng_state_e                               state;
  logic [CFG_DATA_WIDTH-1:0]                acc;
  logic [CFG_DATA_WIDTH-1:0]                mcand;
  logic [CFG_DATA_WIDTH/2-1:0]              mplier;
  logic [$clog2(CFG_DATA_WIDTH/2)-1:0]      step_cnt;

  // Datapath registers
  always_ff @(posedge clk_gated) begin
    if (state == E_IDLE && job_req_i && !job_ack_o) begin
      mcand  <= CFG_DATA_WIDTH'(operand_a_i[CFG_DATA_WIDTH/2-1:0]);
      mplier <= operand_b_i[CFG_DATA_WIDTH/2-1:0];
      case (opcode_i)
        OP_ADD:  acc <= operand_a_i + operand_b_i;
        OP_SUB:  acc <= operand_a_i - operand_b_i;
        OP_XOR:  acc <= operand_a_i ^ operand_b_i;
        default: acc <= '0;
      endcase
    end else if (state == E_MUL) begin
      // One multiplier bit per cycle, LSB first
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state       <= E_IDLE;
      step_cnt    <= '0;
      job_ack_o   <= 1'b0;
      result_we_o <= 1'b0;
    end else begin
      case (state)
        E_IDLE: begin
          if (job_req_i && !job_ack_o) begin
            step_cnt <= '0;
            state    <= (opcode_i == OP_MUL) ? E_MUL : E_DONE;
          end
        end
        E_MUL: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == '1) begin
            state <= E_DONE;
          end
        end
        E_DONE: begin
          if (!job_ack_o) begin
            // Result write and ack rise together
            job_ack_o   <= 1'b1;
            result_we_o <= 1'b1;
          end else begin
            result_we_o <= 1'b0;
            if (!job_req_i) begin
              job_ack_o <= 1'b0;
              state     <= E_IDLE;
            end
          end
        end
        default: begin
          state       <= E_IDLE;
          job_ack_o   <= 1'b0;
          result_we_o <= 1'b0;
        end
      endcase
    end
  end

  assign result_data_o = acc;

endmodule

/* verilog/hwpe_sm_pkg.sv */
// ************************************************
// Shared-memory accelerator wrapper package
// Sizes, register map, opcodes and FSM states
// shared by slave, register file and engine
// ************************************************

package hwpe_sm_pkg;

  // Job contexts
  localparam int N_CONTEXT   = 2;
  localparam int LOG_CONTEXT = $clog2(N_CONTEXT);

  // Peripheral bus
  localparam int CFG_ADDR_WIDTH = 11;
  localparam int CFG_DATA_WIDTH = 32;

  // Registers in one context window
  localparam int N_REGISTERS      = 8;
  localparam int LOG_REGS         = $clog2(N_REGISTERS);
  localparam int N_MANDATORY_REGS = 4;

  // Register map
  localparam logic [LOG_REGS-1:0] REG_TRIGGER   = 3'd0;
  localparam logic [LOG_REGS-1:0] REG_ACQUIRE   = 3'd1;
  localparam logic [LOG_REGS-1:0] REG_STATUS    = 3'd2;
  localparam logic [LOG_REGS-1:0] REG_RESERVED  = 3'd3;
  localparam logic [LOG_REGS-1:0] REG_OPCODE    = 3'd4;
  localparam logic [LOG_REGS-1:0] REG_OPERAND_A = 3'd5;
  localparam logic [LOG_REGS-1:0] REG_OPERAND_B = 3'd6;
  localparam logic [LOG_REGS-1:0] REG_RESULT    = 3'd7;

  // Refused test-and-set
  localparam logic [CFG_DATA_WIDTH-1:0] ACQUIRE_BUSY = 32'hFFFF_FFFF;

  // Engine opcodes, mul uses the low half of each operand
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } engine_op_e;

  typedef enum logic [1:0] {IDLE, STARTING, RUNNING, DRAINING} run_state_e;

  typedef enum logic {IDLE_C, CRITICAL} ctx_state_e;

  typedef enum logic [1:0] {E_IDLE, E_MUL, E_DONE} eng_state_e;

endpackage

/* verilog/hwpe_sm_regfile.sv */
// ************************************************
// Accelerator wrapper context register file
// Opcode, operands and result per job context
// ************************************************

`timescale 1ns/1ps

module hwpe_sm_regfile import hwpe_sm_pkg::*; (
  input  logic                            clk_gated,
  input  logic                            rst_n,

  // Bus side from the slave
  input  logic                            wren_i,
  input  logic                            rden_i,
  input  logic [LOG_CONTEXT+LOG_REGS-1:0] addr_i,
  input  logic [CFG_DATA_WIDTH-1:0]       wdata_i,
  output logic [CFG_DATA_WIDTH-1:0]       rdata_o,

  // Engine side
  input  logic [LOG_CONTEXT-1:0]          running_context_i,
  output engine_op_e                      opcode_o,
  output logic [CFG_DATA_WIDTH-1:0]       operand_a_o,
  output logic [CFG_DATA_WIDTH-1:0]       operand_b_o,
  input  logic                            result_we_i,
  input  logic [CFG_DATA_WIDTH-1:0]       result_data_i
);

  engine_op_e                opcode_q    [N_CONTEXT];
  logic [CFG_DATA_WIDTH-1:0] operand_a_q [N_CONTEXT];
  logic [CFG_DATA_WIDTH-1:0] operand_b_q [N_CONTEXT];
  logic [CFG_DATA_WIDTH-1:0] result_q    [N_CONTEXT];
  logic [LOG_CONTEXT-1:0]    ctx;
  logic [LOG_REGS-1:0]       idx;

  assign ctx = addr_i[LOG_REGS +: LOG_CONTEXT];
  assign idx = addr_i[LOG_REGS-1:0];

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_CONTEXT; i++) begin
        opcode_q[i]    <= OP_ADD;
        operand_a_q[i] <= '0;
        operand_b_q[i] <= '0;
        result_q[i]    <= '0;
      end
    end else begin
      // Result is written by the engine only
      if (wren_i) begin
        case (idx)
          REG_OPCODE:    opcode_q[ctx]    <= engine_op_e'(wdata_i[$bits(engine_op_e)-1:0]);
          REG_OPERAND_A: operand_a_q[ctx] <= wdata_i;
          REG_OPERAND_B: operand_b_q[ctx] <= wdata_i;
          default: ;
        endcase
      end
      if (result_we_i) begin
        result_q[running_context_i] <= result_data_i;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rden_i) begin
      case (idx)
        REG_OPCODE:    rdata_o = CFG_DATA_WIDTH'(opcode_q[ctx]);
        REG_OPERAND_A: rdata_o = operand_a_q[ctx];
        REG_OPERAND_B: rdata_o = operand_b_q[ctx];
        REG_RESULT:    rdata_o = result_q[ctx];
        default:       rdata_o = '0;
      endcase
    end
  end

  // Job fields of the running context
  assign opcode_o    = opcode_q[running_context_i];
  assign operand_a_o = operand_a_q[running_context_i];
  assign operand_b_o = operand_b_q[running_context_i];

endmodule

/* verilog/hwpe_sm_slave.sv */
// ************************************************
// Accelerator wrapper slave control
// Bus decode, context pointers, test-and-set,
// job handshake and completion interrupt
// ************************************************

`timescale 1ns/1ps

module hwpe_sm_slave import hwpe_sm_pkg::*; (
  input  logic                            clk_gated,
  input  logic                            rst_n,

  // Peripheral bus
  input  logic                            data_req_i,
  input  logic [CFG_ADDR_WIDTH-1:0]       data_add_i,
  input  logic                            data_type_i,
  input  logic [CFG_DATA_WIDTH-1:0]       data_wdata_i,
  output logic [CFG_DATA_WIDTH-1:0]       data_r_rdata_o,
  output logic                            data_r_valid_o,

  // Register file
  output logic                            rf_wren_o,
  output logic                            rf_rden_o,
  output logic [LOG_CONTEXT+LOG_REGS-1:0] rf_addr_o,
  output logic [CFG_DATA_WIDTH-1:0]       rf_wdata_o,
  output logic [LOG_CONTEXT-1:0]          running_context_o,
  input  logic [CFG_DATA_WIDTH-1:0]       rf_rdata_i,

  // Engine handshake
  output logic                            job_req_o,
  input  logic                            job_ack_i,

  output logic                            evt_interrupt_o
);

  logic                      req_phase;
  logic                      bus_act;
  logic [LOG_REGS-1:0]       reg_idx;
  logic [LOG_CONTEXT-1:0]    addr_ctx;
  logic                      is_mandatory;
  logic                      is_trigger;
  logic                      is_acquire;
  logic                      acquire_ok;
  logic [LOG_CONTEXT-1:0]    pointer_context;
  logic [LOG_CONTEXT-1:0]    running_context;
  logic [LOG_CONTEXT:0]      pending;
  logic                      full;
  logic                      working;
  logic                      job_done;
  logic [CFG_DATA_WIDTH-1:0] rd_value;
  logic [1:0]                irq_q;
  run_state_e                run_state;
  ctx_state_e                ctx_state;

  // Second cycle of a two-cycle request is the acting one
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      req_phase <= 1'b0;
    end else if (req_phase) begin
      req_phase <= 1'b0;
    end else begin
      req_phase <= data_req_i;
    end
  end

  assign bus_act  = data_req_i & req_phase;
  assign reg_idx  = data_add_i[LOG_REGS-1:0];
  assign addr_ctx = data_add_i[LOG_REGS +: LOG_CONTEXT];

  assign is_mandatory = reg_idx < LOG_REGS'(N_MANDATORY_REGS);
  assign full         = pending == (LOG_CONTEXT+1)'(N_CONTEXT);
  assign acquire_ok   = (ctx_state == IDLE_C) && !full;
  assign is_acquire   = bus_act && !data_type_i && (reg_idx == REG_ACQUIRE);
  // No new trigger once every context is pending
  assign is_trigger   = bus_act && data_type_i && (reg_idx == REG_TRIGGER) &&
                        (data_wdata_i == CFG_DATA_WIDTH'(1)) && !full;

  // Writes land in the acquired context, reads pick any context
  assign rf_wren_o  = bus_act & data_type_i & ~is_mandatory;
  assign rf_rden_o  = bus_act & ~data_type_i & ~is_mandatory;
  assign rf_addr_o  = {data_type_i ? pointer_context : addr_ctx, reg_idx};
  assign rf_wdata_o = data_wdata_i;

  assign running_context_o = running_context;
  assign working           = run_state != IDLE;
  assign job_done          = (run_state == RUNNING) && job_ack_i;

  always_comb begin
    case (reg_idx)
      REG_TRIGGER:  rd_value = '0;
      REG_ACQUIRE:  rd_value = acquire_ok ? CFG_DATA_WIDTH'(pointer_context) : ACQUIRE_BUSY;
      REG_STATUS:   rd_value = CFG_DATA_WIDTH'({pending, working});
      REG_RESERVED: rd_value = '0;
      default:      rd_value = rf_rdata_i;
    endcase
  end

  // Read data held for the valid cycle
  always_ff @(posedge clk_gated) begin
    if (bus_act && !data_type_i) begin
      data_r_rdata_o <= rd_value;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      data_r_valid_o <= 1'b0;
    end else begin
      data_r_valid_o <= bus_act & ~data_type_i;
    end
  end

  // Context accounting
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      pointer_context <= '0;
      running_context <= '0;
      pending         <= '0;
    end else begin
      if (is_trigger) begin
        pointer_context <= pointer_context + 1'b1;
      end
      if (job_done) begin
        running_context <= running_context + 1'b1;
      end
      case ({is_trigger, job_done})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  // Critical section between acquire and trigger
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      ctx_state <= IDLE_C;
    end else begin
      case (ctx_state)
        IDLE_C: begin
          if (is_acquire && acquire_ok) begin
            ctx_state <= CRITICAL;
          end
        end
        CRITICAL: begin
          if (is_trigger) begin
            ctx_state <= IDLE_C;
          end
        end
        default: ctx_state <= IDLE_C;
      endcase
    end
  end

  // Job FSM, four-phase req/ack with the engine
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      run_state <= IDLE;
      job_req_o <= 1'b0;
    end else begin
      case (run_state)
        IDLE: begin
          if (pending != '0) begin
            run_state <= STARTING;
          end
        end
        STARTING: begin
          run_state <= RUNNING;
          job_req_o <= 1'b1;
        end
        RUNNING: begin
          if (job_ack_i) begin
            run_state <= DRAINING;
            job_req_o <= 1'b0;
          end
        end
        DRAINING: begin
          // Wait for the engine to release ack
          if (!job_ack_i) begin
            run_state <= IDLE;
          end
        end
        default: begin
          run_state <= IDLE;
          job_req_o <= 1'b0;
        end
      endcase
    end
  end

  // Two-cycle pulse per completed job
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= 2'b00;
    end else begin
      irq_q <= {irq_q[0], job_done};
    end
  end

  assign evt_interrupt_o = |irq_q;

endmodule

/* verilog/hwpe_sm_top.sv */
// ************************************************
// Accelerator wrapper top level
// Slave control, context registers and engine
// ************************************************

`timescale 1ns/1ps

module hwpe_sm_top import hwpe_sm_pkg::*; (
  input  logic                      clk_gated,
  input  logic                      rst_n,

  input  logic                      data_req_i,
  input  logic [CFG_ADDR_WIDTH-1:0] data_add_i,
  input  logic                      data_type_i,
  input  logic [CFG_DATA_WIDTH-1:0] data_wdata_i,
  output logic [CFG_DATA_WIDTH-1:0] data_r_rdata_o,
  output logic                      data_r_valid_o,

  output logic                      evt_interrupt_o
);

  logic                            rf_wren;
  logic                            rf_rden;
  logic [LOG_CONTEXT+LOG_REGS-1:0] rf_addr;
  logic [CFG_DATA_WIDTH-1:0]       rf_wdata;
  logic [CFG_DATA_WIDTH-1:0]       rf_rdata;
  logic [LOG_CONTEXT-1:0]          running_context;
  logic                            job_req;
  logic                            job_ack;
  engine_op_e                      opcode;
  logic [CFG_DATA_WIDTH-1:0]       operand_a;
  logic [CFG_DATA_WIDTH-1:0]       operand_b;
  logic                            result_we;
  logic [CFG_DATA_WIDTH-1:0]       result_data;

  hwpe_sm_slave slave_i (
    .clk_gated         (clk_gated),
    .rst_n             (rst_n),
    .data_req_i        (data_req_i),
    .data_add_i        (data_add_i),
    .data_type_i       (data_type_i),
    .data_wdata_i      (data_wdata_i),
    .data_r_rdata_o    (data_r_rdata_o),
    .data_r_valid_o    (data_r_valid_o),
    .rf_wren_o         (rf_wren),
    .rf_rden_o         (rf_rden),
    .rf_addr_o         (rf_addr),
    .rf_wdata_o        (rf_wdata),
    .running_context_o (running_context),
    .rf_rdata_i        (rf_rdata),
    .job_req_o         (job_req),
    .job_ack_i         (job_ack),
    .evt_interrupt_o   (evt_interrupt_o)
  );

  hwpe_sm_regfile regfile_i (
    .clk_gated         (clk_gated),
    .rst_n             (rst_n),
    .wren_i            (rf_wren),
    .rden_i            (rf_rden),
    .addr_i            (rf_addr),
    .wdata_i           (rf_wdata),
    .rdata_o           (rf_rdata),
    .running_context_i (running_context),
    .opcode_o          (opcode),
    .operand_a_o       (operand_a),
    .operand_b_o       (operand_b),
    .result_we_i       (result_we),
    .result_data_i     (result_data)
  );

  hwpe_sm_engine engine_i (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .job_req_i     (job_req),
    .job_ack_o     (job_ack),
    .opcode_i      (opcode),
    .operand_a_i   (operand_a),
    .operand_b_i   (operand_b),
    .result_we_o   (result_we),
    .result_data_o (result_data)
  );

endmodule
